// ==== src/sb_cfg_pkg.sv ====
// Sizing and timing constants for the store buffer
// Queue depth and pointer widths, bus widths and the watchdog limit
package sb_cfg_pkg;

    // ------------------------------------------------------------------
    // Queue sizing
    // ------------------------------------------------------------------

    // Number of store entries held in the circular queue
    localparam int SB_DEPTH = 4;
    // Slot index width, without the wrap bit
    localparam int SB_IDX_W = $clog2(SB_DEPTH);
    // Pointer width, the extra MSB tells full from empty
    localparam int SB_PTR_W = SB_IDX_W + 1;

    // ------------------------------------------------------------------
    // Bus sizing
    // ------------------------------------------------------------------

    // Word address, the two byte offset bits are dropped
    localparam int ADDR_W = 30;
    localparam int DATA_W = 32;
    localparam int SEL_W  = 4;
    // Width of one byte lane
    localparam int BYTE_W = DATA_W / SEL_W;

    // Wait cycles before an unacknowledged write is abandoned
    localparam int WDT_LIMIT = 16;
    localparam int WDT_W     = $clog2(WDT_LIMIT);

endpackage

// ==== src/sb_types_pkg.sv ====
// Packed structs shared by the store buffer blocks
// Store entry, forwarding answer and master side of the Wishbone bus
package sb_types_pkg;

    // One buffered store, a word address with per byte enables
    typedef struct packed {
        logic [sb_cfg_pkg::ADDR_W-1:0] adr;
        logic [sb_cfg_pkg::DATA_W-1:0] dat;
        logic [sb_cfg_pkg::SEL_W-1:0]  sel;
    } sb_entry_t;

    // Answer to a load lookup
    // A hit bit per byte lane, data lanes without a hit read as zero
    typedef struct packed {
        logic [sb_cfg_pkg::SEL_W-1:0]  hit;
        logic [sb_cfg_pkg::DATA_W-1:0] dat;
    } sb_fwd_t;

    // ------------------------------------------------------------------
    // Wishbone classic, signals driven by the master
    // ------------------------------------------------------------------

    typedef struct packed {
        logic                          cyc;
        logic                          stb;
        logic                          we;
        logic [sb_cfg_pkg::ADDR_W-1:0] adr;
        logic [sb_cfg_pkg::SEL_W-1:0]  sel;
        logic [sb_cfg_pkg::DATA_W-1:0] dat;
    } wb_m2s_t;

endpackage

// ==== src/bus_watchdog.sv ====
// Wait cycle counter for an outstanding bus write
// Flags expiry once the write has waited the full limit
`timescale 1ns/1ps

module bus_watchdog (
    input  logic clk_i,
    input  logic rst_n_i,
    input  logic run_i,
    output logic expired_o
);

    localparam logic [sb_cfg_pkg::WDT_W-1:0] LAST_CNT =
        sb_cfg_pkg::WDT_W'(sb_cfg_pkg::WDT_LIMIT - 1);

    logic [sb_cfg_pkg::WDT_W-1:0] cnt_q;

    // Counts cycles with the write on the bus, back to zero once it ends
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            cnt_q <= '0;
        end else if (!run_i) begin
            cnt_q <= '0;
        end else if (cnt_q != LAST_CNT) begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    // Count starts at zero on the first wait cycle, so the last one is
    // the limit minus one
    assign expired_o = run_i && (cnt_q == LAST_CNT);

endmodule

// ==== src/wb_drain_fsm.sv ====
// Drain state machine, Wishbone classic write master
// Writes the oldest queue entry, pops it on ack or watchdog expiry
// Holds a sticky error flag for writes dropped by the watchdog
`timescale 1ns/1ps

module wb_drain_fsm (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    // Queue head
    input  logic                    head_valid_i,
    input  sb_types_pkg::sb_entry_t head_entry_i,
    // Bus
    output sb_types_pkg::wb_m2s_t   wb_m2s_o,
    input  logic                    wb_ack_i,
    // Watchdog
    input  logic                    wdt_expired_i,
    // Queue control and status
    output logic                    pop_o,
    output logic                    draining_o,
    output logic                    wdt_run_o,
    output logic                    drop_err_o
);

    typedef enum logic [1:0] {
        IDLE,
        WRITE,
        GAP
    } drain_state_t;

    drain_state_t state_q;
    drain_state_t state_d;

    // Copy of the head taken when the write starts
    sb_types_pkg::sb_entry_t bus_entry_q;
    logic                    drop_err_q;
    logic                    write_done;

    // Either an ack or the watchdog ends the write and retires the entry
    assign write_done = (state_q == WRITE) && (wb_ack_i || wdt_expired_i);

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (head_valid_i) begin
                    state_d = WRITE;
                end
            end
            WRITE: begin
                if (write_done) begin
                    state_d = GAP;
                end
            end
            // One cycle with cyc low between two writes
            GAP: state_d = IDLE;
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q    <= IDLE;
            drop_err_q <= 1'b0;
        end else begin
            state_q <= state_d;
            // Ack wins if it shows up on the expiry cycle
            if ((state_q == WRITE) && wdt_expired_i && !wb_ack_i) begin
                drop_err_q <= 1'b1;
            end
        end
    end

    // Address, data and select stay frozen for the whole write
    always_ff @(posedge clk_i) begin
        if ((state_q == IDLE) && head_valid_i) begin
            bus_entry_q <= head_entry_i;
        end
    end

    // cyc, stb and we all follow the WRITE state register
    assign wb_m2s_o.cyc = (state_q == WRITE);
    assign wb_m2s_o.stb = (state_q == WRITE);
    assign wb_m2s_o.we  = (state_q == WRITE);
    assign wb_m2s_o.adr = bus_entry_q.adr;
    assign wb_m2s_o.sel = bus_entry_q.sel;
    assign wb_m2s_o.dat = bus_entry_q.dat;

    assign pop_o      = write_done;
    assign wdt_run_o  = (state_q == WRITE);
    assign drop_err_o = drop_err_q;

    // The head is locked from the capture cycle until it is popped
    assign draining_o = (state_q == WRITE) || ((state_q == IDLE) && head_valid_i);

endmodule

// ==== src/store_buffer.sv ====
// Circular store queue for the data side
// Pushes merge into a pending entry with the same word address
// Combinational store-to-load forwarding, youngest byte wins
// Head entry and pop for the drain machine
`timescale 1ns/1ps

module store_buffer (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    // Store unit
    input  logic                    st_valid_i,
    input  sb_types_pkg::sb_entry_t st_entry_i,
    output logic                    st_ready_o,
    // Load unit lookup
    input  logic [sb_cfg_pkg::ADDR_W-1:0] ld_addr_i,
    output sb_types_pkg::sb_fwd_t   ld_fwd_o,
    // Drain side
    input  logic                    pop_i,
    input  logic                    draining_i,
    output logic                    head_valid_o,
    output sb_types_pkg::sb_entry_t head_entry_o,
    output logic                    empty_o
);

    // ------------------------------------------------------------------
    // Storage and pointers
    // ------------------------------------------------------------------

    sb_types_pkg::sb_entry_t mem_q [sb_cfg_pkg::SB_DEPTH];

    // Pointers carry a wrap bit above the slot index
    logic [sb_cfg_pkg::SB_PTR_W-1:0] wr_ptr_q;
    logic [sb_cfg_pkg::SB_PTR_W-1:0] rd_ptr_q;
    logic [sb_cfg_pkg::SB_IDX_W-1:0] wr_idx;
    logic [sb_cfg_pkg::SB_IDX_W-1:0] rd_idx;
    // Number of occupied slots
    logic [sb_cfg_pkg::SB_PTR_W-1:0] count;

    logic full;
    logic empty;
    logic push;

    logic [sb_cfg_pkg::SB_DEPTH-1:0] slot_valid;
    logic [sb_cfg_pkg::SB_DEPTH-1:0] merge_match;
    logic                            merge_hit;
    logic [sb_cfg_pkg::SB_IDX_W-1:0] merge_idx;
    sb_types_pkg::sb_entry_t         merged_entry;

    assign wr_idx = wr_ptr_q[sb_cfg_pkg::SB_IDX_W-1:0];
    assign rd_idx = rd_ptr_q[sb_cfg_pkg::SB_IDX_W-1:0];
    assign count  = wr_ptr_q - rd_ptr_q;

    // Same index with different wrap bits means every slot is taken
    assign empty = (wr_ptr_q == rd_ptr_q);
    assign full  = (wr_idx == rd_idx) && (wr_ptr_q[sb_cfg_pkg::SB_PTR_W-1] !=
                                          rd_ptr_q[sb_cfg_pkg::SB_PTR_W-1]);

    // A full queue refuses merges as well as appends
    assign st_ready_o = !full;
    assign push       = st_valid_i && st_ready_o;

    // A slot is live when its distance from the head is below the count
    always_comb begin
        logic [sb_cfg_pkg::SB_IDX_W-1:0] age;
        for (int i = 0; i < sb_cfg_pkg::SB_DEPTH; i++) begin
            age           = sb_cfg_pkg::SB_IDX_W'(i) - rd_idx;
            slot_valid[i] = ({1'b0, age} < count);
        end
    end

    // ------------------------------------------------------------------
    // Merge lookup for the store port
    // ------------------------------------------------------------------

    // The head is left alone while it sits on the bus, a store to the
    // same address then goes into a fresh entry behind it
    always_comb begin
        merge_idx = '0;
        for (int i = 0; i < sb_cfg_pkg::SB_DEPTH; i++) begin
            merge_match[i] = slot_valid[i] && (mem_q[i].adr == st_entry_i.adr) &&
                             !(draining_i && (sb_cfg_pkg::SB_IDX_W'(i) == rd_idx));
            if (merge_match[i]) begin
                merge_idx = sb_cfg_pkg::SB_IDX_W'(i);
            end
        end
    end

    assign merge_hit = |merge_match;

    // Old entry with the enabled bytes of the new store laid over it
    always_comb begin
        merged_entry     = mem_q[merge_idx];
        merged_entry.sel = mem_q[merge_idx].sel | st_entry_i.sel;
        for (int b = 0; b < sb_cfg_pkg::SEL_W; b++) begin
            if (st_entry_i.sel[b]) begin
                merged_entry.dat[b*sb_cfg_pkg::BYTE_W +: sb_cfg_pkg::BYTE_W] =
                    st_entry_i.dat[b*sb_cfg_pkg::BYTE_W +: sb_cfg_pkg::BYTE_W];
            end
        end
    end

    // Entry storage, payload only
    always_ff @(posedge clk_i) begin
        if (push) begin
            if (merge_hit) begin
                mem_q[merge_idx] <= merged_entry;
            end else begin
                mem_q[wr_idx] <= st_entry_i;
            end
        end
    end

    // A merge leaves the write pointer where it is
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
        end else begin
            if (push && !merge_hit) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop_i && !empty) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
        end
    end

    // ------------------------------------------------------------------
    // Load forwarding
    // ------------------------------------------------------------------

    // Walk from oldest to youngest so later stores overwrite earlier bytes
    always_comb begin
        logic [sb_cfg_pkg::SB_IDX_W-1:0] slot;
        ld_fwd_o = '0;
        for (int k = 0; k < sb_cfg_pkg::SB_DEPTH; k++) begin
            slot = rd_idx + sb_cfg_pkg::SB_IDX_W'(k);
            if (slot_valid[slot] && (mem_q[slot].adr == ld_addr_i)) begin
                for (int b = 0; b < sb_cfg_pkg::SEL_W; b++) begin
                    if (mem_q[slot].sel[b]) begin
                        ld_fwd_o.hit[b] = 1'b1;
                        ld_fwd_o.dat[b*sb_cfg_pkg::BYTE_W +: sb_cfg_pkg::BYTE_W] =
                            mem_q[slot].dat[b*sb_cfg_pkg::BYTE_W +: sb_cfg_pkg::BYTE_W];
                    end
                end
            end
        end
    end

    // Oldest entry goes to the drain machine
    assign head_valid_o = !empty;
    assign head_entry_o = mem_q[rd_idx];
    assign empty_o      = empty;

endmodule

// ==== src/store_buffer_top.sv ====
// Store buffer top level
// Queue, drain state machine and bus watchdog wired together
`timescale 1ns/1ps

module store_buffer_top (
    input  logic                          clk_i,
    input  logic                          rst_n_i,
    // Store unit
    input  logic                          st_valid_i,
    input  sb_types_pkg::sb_entry_t       st_entry_i,
    output logic                          st_ready_o,
    // Load unit
    input  logic [sb_cfg_pkg::ADDR_W-1:0] ld_addr_i,
    output sb_types_pkg::sb_fwd_t         ld_fwd_o,
    // Wishbone master, writes only so read data goes nowhere
    output sb_types_pkg::wb_m2s_t         wb_m2s_o,
    input  logic [sb_cfg_pkg::DATA_W-1:0] wb_dat_i,
    input  logic                          wb_ack_i,
    // Status
    output logic                          empty_o,
    output logic                          drop_err_o
);

    logic                    head_valid;
    sb_types_pkg::sb_entry_t head_entry;
    logic                    pop;
    logic                    draining;
    logic                    wdt_run;
    logic                    wdt_expired;

    store_buffer u_store_buffer (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .st_valid_i   (st_valid_i),
        .st_entry_i   (st_entry_i),
        .st_ready_o   (st_ready_o),
        .ld_addr_i    (ld_addr_i),
        .ld_fwd_o     (ld_fwd_o),
        .pop_i        (pop),
        .draining_i   (draining),
        .head_valid_o (head_valid),
        .head_entry_o (head_entry),
        .empty_o      (empty_o)
    );

    wb_drain_fsm u_wb_drain_fsm (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .head_valid_i  (head_valid),
        .head_entry_i  (head_entry),
        .wb_m2s_o      (wb_m2s_o),
        .wb_ack_i      (wb_ack_i),
        .wdt_expired_i (wdt_expired),
        .pop_o         (pop),
        .draining_o    (draining),
        .wdt_run_o     (wdt_run),
        .drop_err_o    (drop_err_o)
    );

    bus_watchdog u_bus_watchdog (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .run_i     (wdt_run),
        .expired_o (wdt_expired)
    );

endmodule

// ==== tb/wb_mem_model.sv ====
// Wishbone classic slave memory for the store buffer testbench
// Random wait states of 0 to 3 cycles per write, an external stall
// input and a top address region that never acknowledges
`timescale 1ns/1ps

module wb_mem_model #(
    parameter int MEM_WORDS = 64,
    parameter int SEED      = 0
) (
    input  logic                          clk_i,
    input  logic                          rst_n_i,
    input  sb_types_pkg::wb_m2s_t         wb_m2s_i,
    input  logic                          stall_i,
    output logic [sb_cfg_pkg::DATA_W-1:0] wb_dat_o,
    output logic                          wb_ack_o
);

    localparam int IDX_W  = $clog2(MEM_WORDS);
    localparam int BYTE_W = sb_cfg_pkg::BYTE_W;

    logic [sb_cfg_pkg::DATA_W-1:0] mem [MEM_WORDS];
    logic [IDX_W-1:0]              idx;
    logic                          unmapped;
    logic                          busy_q;
    logic [1:0]                    wait_q;
    logic                          ack_q;
    int                            seed;

    // Every word starts with a value built from its own address
    initial begin
        seed = SEED;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = 32'h5a5a_0000 ^ (32'(i) * 32'h0101_0001);
        end
    end

    assign idx      = wb_m2s_i.adr[IDX_W-1:0];
    // The top half of the address space has no slave behind it
    assign unmapped = wb_m2s_i.adr[sb_cfg_pkg::ADDR_W-1];
    assign wb_dat_o = mem[idx];
    assign wb_ack_o = ack_q;

    always @(posedge clk_i) begin
        int draw;
        if (!rst_n_i) begin
            busy_q <= 1'b0;
            wait_q <= '0;
            ack_q  <= 1'b0;
        end else begin
            ack_q <= 1'b0;
            if (!wb_m2s_i.cyc || !wb_m2s_i.stb) begin
                busy_q <= 1'b0;
            end else if (!ack_q) begin
                // First cycle of a request picks its wait states
                if (!busy_q) begin
                    draw   = $random(seed);
                    busy_q <= 1'b1;
                    wait_q <= draw[1:0];
                end else if (wait_q != 2'd0) begin
                    wait_q <= wait_q - 2'd1;
                end else if (!stall_i && !unmapped) begin
                    ack_q  <= 1'b1;
                    busy_q <= 1'b0;
                    for (int b = 0; b < sb_cfg_pkg::SEL_W; b++) begin
                        if (wb_m2s_i.sel[b]) begin
                            mem[idx][b*BYTE_W +: BYTE_W] <= wb_m2s_i.dat[b*BYTE_W +: BYTE_W];
                        end
                    end
                end
            end
        end
    end

endmodule

// ==== tb/tb_store_buffer_top.sv ====
// Testbench for the store buffer top level
// Clock and reset, directed and random stores, a memory model with stall
// A reference model of memory and of pending stores, checked by assertions
`timescale 1ns/1ps

module tb_store_buffer_top;

    localparam int CLK_PERIOD = 20;
    localparam int MEM_WORDS  = 64;
    localparam int MEM_IDX_W  = $clog2(MEM_WORDS);
    localparam int WAIT_LIMIT = 500;
    localparam int ADDR_W     = sb_cfg_pkg::ADDR_W;
    localparam int DATA_W     = sb_cfg_pkg::DATA_W;
    localparam int SEL_W      = sb_cfg_pkg::SEL_W;
    localparam int BYTE_W     = sb_cfg_pkg::BYTE_W;

    // One accepted store and the clock edge that took it
    typedef struct packed {
        sb_types_pkg::sb_entry_t ent;
        logic [31:0]             at_edge;
    } push_rec_t;

    logic                    clk;
    logic                    rst_n;
    logic                    st_valid;
    sb_types_pkg::sb_entry_t st_entry;
    logic                    st_ready;
    logic [ADDR_W-1:0]       ld_addr;
    sb_types_pkg::sb_fwd_t   ld_fwd;
    sb_types_pkg::wb_m2s_t   wb_m2s;
    logic [DATA_W-1:0]       wb_dat;
    logic                    wb_ack;
    logic                    empty;
    logic                    drop_err;
    logic                    stall;

    integer seed;
    int     mismatch_count;
    int     fail_count;

    // Reference model state
    logic [DATA_W-1:0]     exp_mem [MEM_WORDS];
    push_rec_t             pend_q [$];
    sb_types_pkg::wb_m2s_t bus_log [$];
    int                    push_count;
    logic [31:0]           edge_cnt;
    logic [31:0]           cap_edge;
    logic                  cyc_prev;
    logic [ADDR_W-1:0]     bus_adr;

    store_buffer_top UUT (
        .clk_i      (clk),
        .rst_n_i    (rst_n),
        .st_valid_i (st_valid),
        .st_entry_i (st_entry),
        .st_ready_o (st_ready),
        .ld_addr_i  (ld_addr),
        .ld_fwd_o   (ld_fwd),
        .wb_m2s_o   (wb_m2s),
        .wb_dat_i   (wb_dat),
        .wb_ack_i   (wb_ack),
        .empty_o    (empty),
        .drop_err_o (drop_err)
    );

    wb_mem_model #(.MEM_WORDS(MEM_WORDS), .SEED(32'ha4a6f580)) u_mem (
        .clk_i    (clk),
        .rst_n_i  (rst_n),
        .wb_m2s_i (wb_m2s),
        .stall_i  (stall),
        .wb_dat_o (wb_dat),
        .wb_ack_o (wb_ack)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ------------------------------------------------------------------
    // Checks and helpers
    // ------------------------------------------------------------------

    task automatic check_value(string name, logic [63:0] expected, logic [63:0] actual);
        assert (actual == expected) else begin
            mismatch_count++;
            $display("mismatch %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic report_failure(string what);
        fail_count++;
        $display("error: %s", what);
    endtask

    function automatic logic is_mapped(logic [ADDR_W-1:0] adr);
        return adr < ADDR_W'(MEM_WORDS);
    endfunction

    // Youngest pending byte wins and lanes without a hit stay zero
    function automatic sb_types_pkg::sb_fwd_t expected_fwd(logic [ADDR_W-1:0] adr);
        sb_types_pkg::sb_fwd_t f;
        f = '0;
        foreach (pend_q[i]) begin
            if (pend_q[i].ent.adr == adr) begin
                for (int b = 0; b < SEL_W; b++) begin
                    if (pend_q[i].ent.sel[b]) begin
                        f.hit[b]                   = 1'b1;
                        f.dat[b*BYTE_W +: BYTE_W] = pend_q[i].ent.dat[b*BYTE_W +: BYTE_W];
                    end
                end
            end
        end
        return f;
    endfunction

    task automatic make_store(input logic [ADDR_W-1:0] adr, output sb_types_pkg::sb_entry_t e);
        e.adr = adr;
        e.dat = $random(seed);
        e.sel = SEL_W'($random(seed));
    endtask

    // Keeps valid high until ready was seen and then drops it
    task automatic finish_push();
        int waited;
        waited = 0;
        while (!st_ready && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (!st_ready) begin
            report_failure("store was never accepted by the queue");
        end
        @(negedge clk);
        st_valid = 1'b0;
    endtask

    task automatic push_store(sb_types_pkg::sb_entry_t e);
        @(negedge clk);
        st_valid = 1'b1;
        st_entry = e;
        finish_push();
    endtask

    task automatic wait_drained(string name);
        int waited;
        waited = 0;
        while (!(empty && !wb_m2s.cyc) && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (!empty) begin
            report_failure({"queue did not drain in ", name});
        end
    endtask

    task automatic wait_bus_adr(logic [ADDR_W-1:0] adr);
        int waited;
        waited = 0;
        while (!(wb_m2s.cyc && wb_m2s.adr == adr) && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (!(wb_m2s.cyc && wb_m2s.adr == adr)) begin
            report_failure("expected bus write never started");
        end
    endtask

    task automatic check_memory(string name);
        for (int i = 0; i < MEM_WORDS; i++) begin
            check_value($sformatf("%s word %0d", name, i), 64'(exp_mem[i]), 64'(u_mem.mem[i]));
        end
    endtask

    // Lookup settles a quarter period after the falling edge
    task automatic check_lookup(string name, logic [ADDR_W-1:0] adr);
        sb_types_pkg::sb_fwd_t exp_f;
        @(negedge clk);
        ld_addr = adr;
        #(CLK_PERIOD / 4);
        exp_f = expected_fwd(adr);
        check_value({name, " hit"}, 64'(exp_f.hit), 64'(ld_fwd.hit));
        check_value({name, " data"}, 64'(exp_f.dat), 64'(ld_fwd.dat));
    endtask

    // ------------------------------------------------------------------
    // Monitor, reference model and bus assertion
    // ------------------------------------------------------------------

    // All values read here are the ones before the edge
    always @(posedge clk) begin
        push_rec_t rec;
        edge_cnt = edge_cnt + 1;
        if (rst_n) begin
            // Write ended one edge ago so the pushes merged into it are dropped
            if (cyc_prev && !wb_m2s.cyc) begin
                for (int i = pend_q.size() - 1; i >= 0; i--) begin
                    if (pend_q[i].ent.adr == bus_adr && pend_q[i].at_edge < cap_edge) begin
                        pend_q.delete(i);
                    end
                end
            end
            // The head was copied onto the bus at the edge before cyc rose
            if (wb_m2s.cyc && !cyc_prev) begin
                cap_edge = edge_cnt - 1;
                bus_adr  = wb_m2s.adr;
            end
            if (wb_m2s.cyc && wb_m2s.stb && wb_ack) begin
                bus_log.push_back(wb_m2s);
            end
            if (st_valid && st_ready) begin
                rec.ent     = st_entry;
                rec.at_edge = edge_cnt;
                pend_q.push_back(rec);
                push_count++;
                if (is_mapped(st_entry.adr)) begin
                    for (int b = 0; b < SEL_W; b++) begin
                        if (st_entry.sel[b]) begin
                            exp_mem[st_entry.adr[MEM_IDX_W-1:0]][b*BYTE_W +: BYTE_W] =
                                st_entry.dat[b*BYTE_W +: BYTE_W];
                        end
                    end
                end
            end
            cyc_prev = wb_m2s.cyc;
        end
    end

    // Address, data and select hold still while a write waits for ack
    assert property (@(posedge clk) disable iff (!rst_n)
        (wb_m2s.stb && !wb_ack) |=>
            ($stable(wb_m2s.adr) && $stable(wb_m2s.dat) && $stable(wb_m2s.sel)))
    else report_failure("bus address, data or select changed before ack");

    // The drain machine only writes and never strobes outside a cycle
    assert property (@(posedge clk) disable iff (!rst_n)
        wb_m2s.stb |-> (wb_m2s.cyc && wb_m2s.we))
    else report_failure("bus strobe without cycle or write enable");

    // The drop error is sticky until reset
    assert property (@(posedge clk) disable iff (!rst_n)
        drop_err |=> drop_err)
    else report_failure("drop_err_o fell without a reset");

    // Hard limit on simulated time
    initial begin
        #(CLK_PERIOD * 20000);
        $display("error: simulation ran past its time limit");
        $display("Test failed");
        $finish;
    end

    // ------------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------------

    initial begin
        sb_types_pkg::sb_entry_t e;
        logic [ADDR_W-1:0]       adr_a;
        logic [ADDR_W-1:0]       adr_b;
        logic [DATA_W-1:0]       d1;
        logic [DATA_W-1:0]       d2;
        int                      rnd;
        int                      held_pushes;
        int                      b_writes;
        sb_types_pkg::wb_m2s_t   b_write;

        seed           = 32'ha4a6f580;
        rst_n          = 1'b0;
        st_valid       = 1'b0;
        st_entry       = '0;
        ld_addr        = '0;
        stall          = 1'b0;
        mismatch_count = 0;
        fail_count     = 0;
        push_count     = 0;
        edge_cnt       = '0;
        cap_edge       = '0;
        cyc_prev       = 1'b0;
        bus_adr        = '0;
        b_write        = '0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            exp_mem[i] = 32'h5a5a_0000 ^ (32'(i) * 32'h0101_0001);
        end

        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        // Reset state
        check_value("reset cyc", 64'd0, 64'(wb_m2s.cyc));
        check_value("reset stb", 64'd0, 64'(wb_m2s.stb));
        check_value("reset st_ready", 64'd1, 64'(st_ready));
        check_value("reset empty", 64'd1, 64'(empty));
        check_value("reset drop_err", 64'd0, 64'(drop_err));

        // Ordered drain over a small address range so that merges happen
        for (int n = 0; n < 24; n++) begin
            rnd = $random(seed);
            make_store(ADDR_W'(rnd[3:0]), e);
            push_store(e);
        end
        wait_drained("ordered drain");
        check_memory("ordered drain");

        // Merge and forwarding with the write to A held on the bus
        bus_log.delete();
        adr_a = ADDR_W'(20);
        adr_b = ADDR_W'(21);
        stall = 1'b1;
        make_store(adr_a, e);
        push_store(e);
        wait_bus_adr(adr_a);
        d1 = $random(seed);
        d2 = $random(seed);
        e.adr = adr_b;
        e.dat = d1;
        e.sel = 4'b0011;
        push_store(e);
        e.dat = d2;
        e.sel = 4'b1100;
        push_store(e);
        check_lookup("forward head", adr_a);
        check_lookup("forward merged", adr_b);
        check_lookup("forward absent", ADDR_W'(33));
        check_value("forward absent hit mask", 64'd0, 64'(ld_fwd.hit));
        check_lookup("forward merged direct", adr_b);
        check_value("forward merged full data", 64'({d2[31:16], d1[15:0]}), 64'(ld_fwd.dat));
        @(negedge clk);
        stall = 1'b0;
        wait_drained("merge");
        b_writes = 0;
        foreach (bus_log[i]) begin
            if (bus_log[i].adr == adr_b) begin
                b_writes++;
                b_write = bus_log[i];
            end
        end
        check_value("merge write count", 64'd1, 64'(b_writes));
        check_value("merge select", 64'hf, 64'(b_write.sel));
        check_value("merge data", 64'({d2[31:16], d1[15:0]}), 64'(b_write.dat));
        check_memory("merge");

        // The queue fills up for back-pressure while the bus is held
        stall = 1'b1;
        for (int i = 0; i < sb_cfg_pkg::SB_DEPTH; i++) begin
            make_store(ADDR_W'(40 + i), e);
            push_store(e);
        end
        make_store(ADDR_W'(44), e);
        @(negedge clk);
        st_valid    = 1'b1;
        st_entry    = e;
        held_pushes = push_count;
        repeat (3) begin
            @(negedge clk);
            assert (!st_ready) else report_failure("queue took a store while full");
        end
        check_value("held store push count", 64'(held_pushes), 64'(push_count));
        stall = 1'b0;
        finish_push();
        wait_drained("back-pressure");
        check_memory("back-pressure");

        // Watchdog drop on a write to the unmapped top region
        check_value("drop_err before drop", 64'd0, 64'(drop_err));
        make_store('1, e);
        push_store(e);
        rnd = 0;
        while (!drop_err && rnd < WAIT_LIMIT) begin
            @(negedge clk);
            rnd++;
        end
        assert (drop_err) else report_failure("drop_err_o never rose after the watchdog");
        make_store(ADDR_W'(50), e);
        push_store(e);
        wait_drained("watchdog");
        check_memory("watchdog");
        assert (drop_err) else report_failure("drop_err_o did not stay high");

        $display("store buffer run finished, %0d mismatches, %0d other failures",
                 mismatch_count, fail_count);
        if (mismatch_count == 0 && fail_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== files.f ====
src/sb_cfg_pkg.sv
src/sb_types_pkg.sv
src/bus_watchdog.sv
src/wb_drain_fsm.sv
src/store_buffer.sv
src/store_buffer_top.sv
tb/wb_mem_model.sv
tb/tb_store_buffer_top.sv

// ==== Makefile ====
# Verilator build and run for the store buffer testbench

VERILATOR ?= verilator
TOP       ?= tb_store_buffer_top
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "Test completed successfully"

clean:
	rm -rf $(OBJ_DIR)
